// File: vlog.f
src/predecodePkg.sv
src/insnClassify.sv
src/predecodeCtrl.sv
src/slotCompact.sv
src/predecodeTop.sv
tb/predecodeTb.sv

// File: Bender.yml
package:
  name: predecode

sources:
  - src/predecodePkg.sv
  - src/insnClassify.sv
  - src/predecodeCtrl.sv
  - src/slotCompact.sv
  - src/predecodeTop.sv
  - target: simulation
    files:
      - tb/predecodeTb.sv

// File: tb/predecodeTb.sv
`timescale 1ns/1ns

module predecodeTb
  import predecodePkg::*;
();

  localparam int NumVectors = 7 + 200;

  typedef struct packed {
    slotEntry_t [NumSlots-1:0]     slots;
    slotEntry_t [NumJumpSlots-1:0] jumpSlots;
    logic [NumSlots-1:0]           slotEn;
    logic [NumJumpSlots-1:0]       jumpEn;
    logic                          hasJumps;
    logic                          error;
    logic                          jumpError;
  } result_t;

  logic                          clk = 1'b0;
  logic                          reset;
  logic                          bundleValid;
  logic [BundleWidth-1:0]        bundle;
  logic [OffWidth-1:0]           startOff;
  slotEntry_t [NumSlots-1:0]     slots;
  slotEntry_t [NumJumpSlots-1:0] jumpSlots;
  logic [NumSlots-1:0]           slotEn;
  logic [NumJumpSlots-1:0]       jumpEn;
  logic                          hasJumps;
  logic                          error;
  logic                          jumpError;
  logic                          outValid;

  int                     cycle = 0;
  int                     passCount = 0;
  int                     failCount = 0;
  int                     failAtStart;
  result_t                expQ[$];
  int                     dueQ[$];
  result_t                act;
  result_t                lastSeen = '0;
  logic [BundleWidth-1:0] work;
  int                     pos;
  logic [BundleWidth-1:0] bundleA;
  logic [BundleWidth-1:0] bundleB;
  logic [BundleWidth-1:0] aluBundle;

  predecodeTop uut (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  function automatic insnClass_t classOf(logic [15:0] p, logic isLong);
    insnClass_t c;
    c = '0;
    if (isLong) begin
      if (p[7:0] <= 31) begin
        c.alu = ~p[2];
        c.mul = p[2];
      end else if (p[7:0] >= 40 && p[7:0] <= 45) begin
        c.shift = 1'b1;
      end else if (p[7:0] >= 64 && p[7:0] <= 127) begin
        c.load  = ~p[0];
        c.store = p[0];
      end else if (p[7:0] >= 160 && p[7:0] <= 175) begin
        c.jump = 1'b1;
        c.alu  = 1'b1;
      end else if (p[7:0] >= 180 && p[7:0] <= 182) begin
        c.jump  = 1'b1;
        c.indir = (p[7:0] == 182);
      end else begin
        c.sys = (p[7:0] == 255);
      end
    end else if (p[5:0] <= 15) begin
      c.alu = 1'b1;
    end else if (p[5:0] <= 31) begin
      c.shift = p[0];
    end else if (p[5:0] >= 48 && p[5:0] <= 51) begin
      c.jump = 1'b1;
      c.alu  = 1'b1;
    end
    return c;
  endfunction

  function automatic result_t predecodeModel(logic [BundleWidth-1:0] b, logic [OffWidth-1:0] off);
    result_t                 e;
    slotEntry_t              ent;
    logic [NumParcels-1:0]   ends;
    logic [EndBase+79:0]     pad;
    int                      nStart;
    int                      nJump;
    e      = '0;
    ends   = b[EndBase +: NumParcels];
    pad    = {80'h0, b[EndBase-1:0]};
    nStart = 0;
    nJump  = 0;
    for (int k = 0; k < NumParcels; k++) begin
      if (k >= off && (k == 0 ? 1'b1 : ends[k-1])) begin
        ent.insn = pad[16*k +: WindowWidth];
        for (int m = 0; m < MagicWidth; m++) begin
          ent.magic[m] = (k + m < NumParcels) ? ~ends[k+m] : 1'b1;
        end
        ent.off = k;
        ent.cls = classOf(pad[16*k +: 16], ent.magic[0]);
        if (nStart < NumSlots) e.slots[nStart] = ent;
        if (ent.cls.jump && nJump < NumJumpSlots) e.jumpSlots[nJump] = ent;
        nJump  = nJump + ent.cls.jump;
        nStart = nStart + 1;
      end
    end
    for (int i = 0; i < NumSlots; i++) e.slotEn[i] = (nStart > i);
    for (int j = 0; j < NumJumpSlots; j++) e.jumpEn[j] = (nJump > j);
    e.hasJumps  = (nJump > 0);
    e.error     = (nStart > NumSlots) || (off == 15);
    e.jumpError = (nJump > NumJumpSlots);
    return e;
  endfunction

  task automatic checkValue(string name, logic [127:0] got, logic [127:0] exp);
    if (got !== exp) begin
      failCount++;
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end else begin
      passCount++;
    end
  endtask

  task automatic compareResult(string tag, result_t a, result_t e);
    for (int i = 0; i < NumSlots + NumJumpSlots; i++) begin
      slotEntry_t sa;
      slotEntry_t se;
      sa = (i < NumSlots) ? a.slots[i] : a.jumpSlots[i-NumSlots];
      se = (i < NumSlots) ? e.slots[i] : e.jumpSlots[i-NumSlots];
      checkValue($sformatf("%sentry%0d.insn", tag, i), sa.insn, se.insn);
      checkValue($sformatf("%sentry%0d.magic", tag, i), sa.magic, se.magic);
      checkValue($sformatf("%sentry%0d.off", tag, i), sa.off, se.off);
      checkValue($sformatf("%sentry%0d.cls", tag, i), sa.cls, se.cls);
    end
    checkValue({tag, "slotEn"}, a.slotEn, e.slotEn);
    checkValue({tag, "jumpEn"}, a.jumpEn, e.jumpEn);
    checkValue({tag, "flags"}, {a.hasJumps, a.error, a.jumpError},
               {e.hasJumps, e.error, e.jumpError});
  endtask

  // results are compared mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      act = '{slots, jumpSlots, slotEn, jumpEn, hasJumps, error, jumpError};
      if (outValid && expQ.size() == 0) begin
        failCount++;
        $display("outValid was high at %0t ns with no bundle in flight", $time);
      end else if (outValid) begin
        if (dueQ[0] != cycle) begin
          failCount++;
          $display("a result came at cycle %0d instead of cycle %0d", cycle, dueQ[0]);
        end
        compareResult("", act, expQ.pop_front());
        void'(dueQ.pop_front());
      end else begin
        if (expQ.size() != 0 && dueQ[0] <= cycle) begin
          failCount++;
          $display("no outValid for the bundle due at cycle %0d", dueQ[0]);
          void'(expQ.pop_front());
          void'(dueQ.pop_front());
        end
        compareResult("hold ", act, lastSeen);
      end
      if (outValid) lastSeen = act;
    end
  end

  task automatic sendBundle(logic [BundleWidth-1:0] b, logic [OffWidth-1:0] off, bit valid);
    @(posedge clk);
    #2;
    bundle      = b;
    startOff    = off;
    bundleValid = valid;
    if (valid) begin
      expQ.push_back(predecodeModel(b, off));
      dueQ.push_back(cycle + 1);
    end
  endtask

  task automatic finishTest(string name);
    @(posedge clk);
    #2;
    bundleValid = 1'b0;
    while (expQ.size() != 0) @(negedge clk);
    @(negedge clk);
    $display("test %s finished with %0d errors", name, failCount - failAtStart);
    failAtStart = failCount;
  endtask

  // lays one instruction into the bundle and sets the end bit of its last parcel
  task automatic addInsn(logic [63:0] body, int len);
    for (int p = 0; p < len; p++) work[16*(pos+p) +: 16] = body[16*p +: 16];
    work[EndBase+pos+len-1] = 1'b1;
    pos = pos + len;
  endtask

  function automatic logic [63:0] longInsn(logic [7:0] op);
    return {48'h5a3c_96e1_7b2d, 8'h4f, op};
  endfunction

  function automatic logic [63:0] shortInsn(logic [5:0] op);
    return {48'h0, 10'h2e5, op};
  endfunction

  initial begin
    #((NumVectors + 100) * 40);
    $display("timeout: the run did not finish in time");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    void'($urandom(32'hfcb3));
    reset       = 1'b1;
    bundleValid = 1'b0;
    bundle      = '0;
    startOff    = '0;
    failAtStart = 0;
    for (int r = 0; r < 3; r++) begin
      @(posedge clk);
      #2;
      if (r == 1) reset = 1'b0;
      @(negedge clk);
      checkValue("reset outputs", {outValid, slotEn, jumpEn, error, jumpError}, '0);
    end
    finishTest("reset");

    work = '0;
    pos  = 0;
    addInsn(longInsn(8'd42), 4);
    addInsn(longInsn(8'h01), 2);
    addInsn(longInsn(8'h04), 2);
    addInsn(longInsn(8'd64), 2);
    addInsn(shortInsn(6'd3), 1);
    addInsn(shortInsn(6'd17), 1);
    addInsn(shortInsn(6'd16), 1);
    addInsn(longInsn(8'd50), 2);
    bundleA = work;
    work = '0;
    pos  = 0;
    addInsn(longInsn(8'd65), 2);
    addInsn(longInsn(8'd165), 2);
    addInsn(longInsn(8'd181), 2);
    addInsn(longInsn(8'd182), 2);
    addInsn(longInsn(8'd255), 2);
    addInsn(shortInsn(6'd49), 1);
    addInsn(longInsn(8'd180), 2);
    addInsn(shortInsn(6'd2), 1);
    addInsn(shortInsn(6'd32), 1);
    bundleB = work;
    sendBundle(bundleA, 4'd0, 1'b1);
    sendBundle(bundleB, 4'd0, 1'b1);
    finishTest("mixed lengths");

    work = '0;
    pos  = 0;
    for (int k = 0; k < NumParcels; k++) addInsn(shortInsn(6'd1), 1);
    aluBundle = work;
    sendBundle(aluBundle, 4'd0, 1'b1);
    finishTest("overflow");

    work = '0;
    pos  = 0;
    addInsn(shortInsn(6'd1), 1);
    addInsn(longInsn(8'd180), 2);
    addInsn(shortInsn(6'd48), 1);
    addInsn(longInsn(8'h10), 2);
    addInsn(longInsn(8'd170), 2);
    sendBundle(work, 4'd0, 1'b1);
    work = '0;
    pos  = 0;
    for (int k = 0; k < 7; k++) addInsn(longInsn(8'd66), 2);
    addInsn(shortInsn(6'd5), 1);
    sendBundle(work, 4'd0, 1'b1);
    finishTest("jumps");

    sendBundle(bundleA, 4'd5, 1'b1);
    sendBundle(aluBundle, 4'd15, 1'b1);
    finishTest("start offset");

    for (int n = 0; n < 200; n++) begin
      for (int w = 0; w < BundleWidth / 32; w++) work[32*w +: 32] = $urandom;
      sendBundle(work, $urandom_range(0, 15), $urandom_range(0, 9) != 0);
    end
    finishTest("random traffic");

    $display("%0d checks passed, %0d checks failed", passCount, failCount);
    if (failCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: src/predecodeTop.sv
`timescale 1ns/1ns

module predecodeTop
  import predecodePkg::*;
(
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          bundleValid,
  input  logic [BundleWidth-1:0]        bundle,
  input  logic [OffWidth-1:0]           startOff,
  output slotEntry_t [NumSlots-1:0]     slots,
  output slotEntry_t [NumJumpSlots-1:0] jumpSlots,
  output logic [NumSlots-1:0]           slotEn,
  output logic [NumJumpSlots-1:0]       jumpEn,
  output logic                          hasJumps,
  output logic                          error,
  output logic                          jumpError,
  output logic                          outValid
);

  localparam int PadWidth = EndBase + WindowWidth - ParcelWidth;

  logic [NumParcels-1:0]                   endBits;
  logic [PadWidth-1:0]                     parcelPad;
  logic [NumParcels+MagicWidth-2:0]        endPad;
  logic [NumParcels-1:0]                   isJump;
  slotEntry_t [NumParcels-1:0]             entries;
  logic [NumSlots-1:0][NumParcels-1:0]     mainSel;
  logic [NumJumpSlots-1:0][NumParcels-1:0] jumpSel;

  assign endBits = bundle[EndBase +: NumParcels];

  // zero parcels and zero end bits past the last parcel
  assign parcelPad = {{(PadWidth-EndBase){1'b0}}, bundle[EndBase-1:0]};
  assign endPad    = {{(MagicWidth-1){1'b0}}, endBits};

  for (genvar k = 0; k < NumParcels; k++) begin : gParcel
    logic [MagicWidth-1:0] magic;
    insnClass_t            cls;

    assign magic = ~endPad[k +: MagicWidth];

    insnClassify classify (
      .word  (parcelPad[k*ParcelWidth +: $bits(insnWord_u)]),
      .magic (magic),
      .cls   (cls)
    );

    assign entries[k] = '{
      insn:  parcelPad[k*ParcelWidth +: WindowWidth],
      magic: magic,
      off:   OffWidth'(k),
      cls:   cls
    };
    assign isJump[k] = cls.jump;
  end

  predecodeCtrl ctrl (
    .clk         (clk),
    .reset       (reset),
    .bundleValid (bundleValid),
    .endBits     (endBits),
    .startOff    (startOff),
    .isJump      (isJump),
    .mainSel     (mainSel),
    .jumpSel     (jumpSel),
    .slotEn      (slotEn),
    .jumpEn      (jumpEn),
    .hasJumps    (hasJumps),
    .error       (error),
    .jumpError   (jumpError),
    .outValid    (outValid)
  );

  slotCompact #(.SlotCount(NumSlots)) mainCompact (
    .clk     (clk),
    .reset   (reset),
    .load    (bundleValid),
    .entries (entries),
    .sel     (mainSel),
    .slots   (slots)
  );

  slotCompact #(.SlotCount(NumJumpSlots)) jumpCompact (
    .clk     (clk),
    .reset   (reset),
    .load    (bundleValid),
    .entries (entries),
    .sel     (jumpSel),
    .slots   (jumpSlots)
  );

endmodule

// File: src/slotCompact.sv
`timescale 1ns/1ns

module slotCompact
  import predecodePkg::*;
#(
  parameter int SlotCount = NumSlots
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 load,
  input  slotEntry_t [NumParcels-1:0]          entries,
  input  logic [SlotCount-1:0][NumParcels-1:0] sel,
  output slotEntry_t [SlotCount-1:0]           slots
);

  slotEntry_t [SlotCount-1:0] slotD;

  // and-or mux, an empty row leaves the slot at zero
  always_comb begin
    for (int i = 0; i < SlotCount; i++) begin
      slotD[i] = '0;
      for (int k = 0; k < NumParcels; k++) begin
        slotD[i] = slotD[i] | (entries[k] & {$bits(slotEntry_t){sel[i][k]}});
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      slots <= '0;
    end else if (load) begin
      slots <= slotD;
    end
  end

  // the or-merge is only correct with at most one source per slot
  for (genvar i = 0; i < SlotCount; i++) begin : gSelChk
    assert property (@(posedge clk) disable iff (reset)
      load |-> $onehot0(sel[i]));
  end

endmodule

// File: src/predecodeCtrl.sv
`timescale 1ns/1ns

module predecodeCtrl
  import predecodePkg::*;
(
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    bundleValid,
  input  logic [NumParcels-1:0]                   endBits,
  input  logic [OffWidth-1:0]                     startOff,
  input  logic [NumParcels-1:0]                   isJump,
  output logic [NumSlots-1:0][NumParcels-1:0]     mainSel,
  output logic [NumJumpSlots-1:0][NumParcels-1:0] jumpSel,
  output logic [NumSlots-1:0]                     slotEn,
  output logic [NumJumpSlots-1:0]                 jumpEn,
  output logic                                    hasJumps,
  output logic                                    error,
  output logic                                    jumpError,
  output logic                                    outValid
);

  logic [NumParcels-1:0]           prevEnd;
  logic [NumParcels-1:0]           offMask;
  logic [NumParcels-1:0]           isStart;
  logic [NumParcels-1:0]           jumpStart;
  logic [$clog2(NumParcels+1)-1:0] startCnt;
  logic [$clog2(NumParcels+1)-1:0] jumpCnt;
  logic [NumSlots-1:0]             slotEnD;
  logic [NumJumpSlots-1:0]         jumpEnD;

  // parcel 0 behaves as if the previous bundle ended
  assign prevEnd = {endBits[NumParcels-2:0], 1'b1};

  always_comb begin
    for (int k = 0; k < NumParcels; k++) begin
      offMask[k] = (k >= startOff);
    end
  end

  assign isStart   = prevEnd & offMask;
  assign jumpStart = isStart & isJump;

  // running prefix counts give each start its ordinal
  always_comb begin
    startCnt = '0;
    jumpCnt  = '0;
    mainSel  = '0;
    jumpSel  = '0;
    for (int k = 0; k < NumParcels; k++) begin
      for (int i = 0; i < NumSlots; i++) begin
        if (isStart[k] && startCnt == i) begin
          mainSel[i][k] = 1'b1;
        end
      end
      for (int j = 0; j < NumJumpSlots; j++) begin
        if (jumpStart[k] && jumpCnt == j) begin
          jumpSel[j][k] = 1'b1;
        end
      end
      startCnt = startCnt + isStart[k];
      jumpCnt  = jumpCnt + jumpStart[k];
    end
  end

  // thermometer masks saturate on their own
  always_comb begin
    for (int i = 0; i < NumSlots; i++) begin
      slotEnD[i] = (startCnt > i);
    end
    for (int j = 0; j < NumJumpSlots; j++) begin
      jumpEnD[j] = (jumpCnt > j);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid  <= 1'b0;
      slotEn    <= '0;
      jumpEn    <= '0;
      hasJumps  <= 1'b0;
      error     <= 1'b0;
      jumpError <= 1'b0;
    end else begin
      outValid <= bundleValid;
      if (bundleValid) begin
        slotEn    <= slotEnD;
        jumpEn    <= jumpEnD;
        hasJumps  <= |jumpStart;
        error     <= (startCnt > NumSlots) || (startOff == OffWidth'(NumParcels));
        jumpError <= (jumpCnt > NumJumpSlots);
      end
    end
  end

  for (genvar i = 0; i < NumSlots; i++) begin : gMainChk
    assert property (@(posedge clk) disable iff (reset)
      bundleValid |-> $onehot0(mainSel[i]));
  end

  for (genvar j = 0; j < NumJumpSlots; j++) begin : gJumpChk
    assert property (@(posedge clk) disable iff (reset)
      bundleValid |-> $onehot0(jumpSel[j]));
  end

endmodule

// File: src/insnClassify.sv
`timescale 1ns/1ns

module insnClassify
  import predecodePkg::*;
(
  input  insnWord_u             word,
  input  logic [MagicWidth-1:0] magic,
  output insnClass_t            cls
);

  logic       isLong;
  logic [7:0] opMain;
  logic [5:0] opSub;

  // first parcel without an end bit means a long instruction
  assign isLong = magic[0];
  assign opMain = word.longView.opcodeMain;
  assign opSub  = word.shortView.opcodeSub;

  always_comb begin
    cls = '0;
    if (isLong) begin
      // basic alu and mul share 0..31, split on bit 2
      if (opMain[7:5] == 3'b000) begin
        cls.alu = ~opMain[2];
        cls.mul = opMain[2];
      end
      if (opMain >= 8'd40 && opMain <= 8'd45) begin
        cls.shift = 1'b1;
      end
      // 64..127 load or store by the low bit
      if (opMain[7:6] == 2'b01) begin
        cls.load  = ~opMain[0];
        cls.store = opMain[0];
      end
      // conditional jumps also need the alu for the compare
      if (opMain[7:4] == 4'hA) begin
        cls.jump = 1'b1;
        cls.alu  = 1'b1;
      end
      if (opMain == 8'd180 || opMain == 8'd181) begin
        cls.jump = 1'b1;
      end
      if (opMain == 8'd182) begin
        cls.jump  = 1'b1;
        cls.indir = 1'b1;
      end
      if (opMain == 8'hFF) begin
        cls.sys = 1'b1;
      end
    end else begin
      if (opSub[5:4] == 2'b00) begin
        cls.alu = 1'b1;
      end
      // even codes in 16..31 stay unclassified
      if (opSub[5:4] == 2'b01 && opSub[0]) begin
        cls.shift = 1'b1;
      end
      if (opSub[5:2] == 4'b1100) begin
        cls.jump = 1'b1;
        cls.alu  = 1'b1;
      end
    end
  end

endmodule

// File: src/predecodePkg.sv
package predecodePkg;

  // bundle geometry
  localparam int NumParcels  = 15;
  localparam int ParcelWidth = 16;
  localparam int BundleWidth = 256;
  localparam int EndBase     = 240;

  // per-slot payload
  localparam int WindowWidth = 80;
  localparam int MagicWidth  = 4;
  localparam int OffWidth    = 4;

  localparam int NumSlots     = 6;
  localparam int NumJumpSlots = 2;

  // one byte of class flags, alu in the top bit
  typedef struct packed {
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic jump;
    logic indir;
    logic sys;
  } insnClass_t;

  // long form, opcode in the low byte
  typedef struct packed {
    logic [23:0] operands;
    logic [7:0]  opcodeMain;
  } insnLong_t;

  // short form, 6-bit opcode
  typedef struct packed {
    logic [25:0] operands;
    logic [5:0]  opcodeSub;
  } insnShort_t;

  // low 32 bits of an instruction, view picked by length
  typedef union packed {
    insnLong_t  longView;
    insnShort_t shortView;
  } insnWord_u;

  typedef struct packed {
    logic [WindowWidth-1:0] insn;
    logic [MagicWidth-1:0]  magic;
    logic [OffWidth-1:0]    off;
    insnClass_t             cls;
  } slotEntry_t;

endpackage
